// ==== design/bmu_pkg.sv ====
// shared widths and opcode encodings for the bit-manipulation unit
// datapath is fixed at 32 bits; other XLEN values are not supported
// encodings above OP_LAST are undefined and flagged as errors by bmu_top
`default_nettype none

package bmu_pkg;

  // operand and result width
  localparam int XLEN = 32;
  // shift amount comes from b[4:0]
  localparam int SHAMT_W = 5;
  // count results need one extra bit so 32 fits
  localparam int COUNT_W = 6;
  // opcode field width
  localparam int OP_W = 6;

  // opcode encodings, 0 to 36 in order
  typedef enum logic [OP_W-1:0] {
    OP_NONE,
    // adder group
    OP_ADD,
    OP_SUB,
    OP_SH1ADD,
    OP_SH2ADD,
    OP_SH3ADD,
    // compares
    OP_SLT,
    OP_SLTU,
    OP_MIN,
    OP_MAX,
    OP_MINU,
    OP_MAXU,
    // bitwise logic, plain and inverted
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ANDN,
    OP_ORN,
    OP_XNOR,
    // shifts and rotates
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_ROL,
    OP_ROR,
    // single-bit ops
    OP_BEXT,
    OP_BSET,
    OP_BCLR,
    OP_BINV,
    // counts
    OP_CLZ,
    OP_CTZ,
    OP_CPOP,
    // extension, packing, byte ops
    OP_SEXT_B,
    OP_SEXT_H,
    OP_PACK,
    OP_PACKU,
    OP_PACKH,
    OP_REV8,
    OP_ORC_B
  } bmu_op_e;

  // highest legal encoding
  localparam logic [OP_W-1:0] OP_LAST = OP_ORC_B;

endpackage

`default_nettype wire

// ==== design/bmu_arith.sv ====
// adder-based ops: add, sub, shNadd, slt/sltu, min/max/minu/maxu
// purely combinational; output is zero for opcodes outside this group
// one shared adder does both the sums and the compares
`default_nettype none

module bmu_arith (
  input  bmu_pkg::bmu_op_e              op,
  input  logic [bmu_pkg::XLEN-1:0]      a,
  input  logic [bmu_pkg::XLEN-1:0]      b,
  output logic [bmu_pkg::XLEN-1:0]      arith_result
);
  import bmu_pkg::*;

  logic            sub_op;
  logic [XLEN-1:0] a_pre;
  logic [XLEN-1:0] b_mod;
  logic [XLEN:0]   sum;
  logic            ov;
  logic            lt_s;
  logic            lt_u;

  // compares need a - b, so they share the subtract path
  assign sub_op = (op == OP_SUB) || (op == OP_SLT) || (op == OP_SLTU) ||
                  (op == OP_MIN) || (op == OP_MAX) || (op == OP_MINU) ||
                  (op == OP_MAXU);

  // zba pre-shift of a
  always_comb begin
    case (op)
      OP_SH1ADD: a_pre = {a[XLEN-2:0], 1'b0};
      OP_SH2ADD: a_pre = {a[XLEN-3:0], 2'b0};
      OP_SH3ADD: a_pre = {a[XLEN-4:0], 3'b0};
      default:   a_pre = a;
    endcase
  end

  // invert b plus carry-in for two's complement subtract
  assign b_mod = sub_op ? ~b : b;
  assign sum   = {1'b0, a_pre} + {1'b0, b_mod} + {{XLEN{1'b0}}, sub_op};

  // signed overflow from operand and sum signs
  assign ov   = (~a[XLEN-1] & ~b_mod[XLEN-1] &  sum[XLEN-1]) |
                ( a[XLEN-1] &  b_mod[XLEN-1] & ~sum[XLEN-1]);
  assign lt_s = sum[XLEN-1] ^ ov;
  // no carry out means a < b unsigned
  assign lt_u = ~sum[XLEN];

  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: arith_result = sum[XLEN-1:0];
      OP_SLT:  arith_result = {{(XLEN-1){1'b0}}, lt_s};
      OP_SLTU: arith_result = {{(XLEN-1){1'b0}}, lt_u};
      // min/max pick an operand by the compare
      OP_MIN:  arith_result = lt_s ? a : b;
      OP_MAX:  arith_result = lt_s ? b : a;
      OP_MINU: arith_result = lt_u ? a : b;
      OP_MAXU: arith_result = lt_u ? b : a;
      default: arith_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/bmu_shift.sv ====
// shifts, rotates, bit extract and single-bit set/clear/invert
// shift amount is b modulo 32; upper bits of b are ignored
// purely combinational; output is zero for other opcodes
`default_nettype none

module bmu_shift (
  input  bmu_pkg::bmu_op_e              op,
  input  logic [bmu_pkg::XLEN-1:0]      a,
  input  logic [bmu_pkg::XLEN-1:0]      b,
  output logic [bmu_pkg::XLEN-1:0]      shift_result
);
  import bmu_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic [SHAMT_W-1:0] neg_amt;
  logic [SHAMT_W-1:0] amount;
  logic [XLEN-2:0]    fill;
  logic [2*XLEN-2:0]  ext;
  logic [2*XLEN-2:0]  ext_shifted;
  logic [XLEN-1:0]    mask;
  logic [XLEN-1:0]    shift_out;
  logic [XLEN-1:0]    onehot;

  assign shamt   = b[SHAMT_W-1:0];
  // left rotate by k is right rotate by 32-k
  assign neg_amt = -shamt;

  // upper half of the extended operand
  always_comb begin
    case (op)
      OP_SRA:                 fill = {(XLEN-1){a[XLEN-1]}};
      OP_SLL, OP_ROL, OP_ROR: fill = a[XLEN-2:0];
      // srl and bext shift in zeros
      default:                fill = '0;
    endcase
  end

  assign ext    = {fill, a};
  assign amount = ((op == OP_SLL) || (op == OP_ROL)) ? neg_amt : shamt;

  // sll is a left rotate with the low bits cleared
  assign mask = (op == OP_SLL) ? ({XLEN{1'b1}} << shamt) : {XLEN{1'b1}};

  // single right shifter for all shift-type ops
  assign ext_shifted = ext >> amount;
  assign shift_out   = ext_shifted[XLEN-1:0] & mask;

  // single-bit position
  assign onehot = {{(XLEN-1){1'b0}}, 1'b1} << shamt;

  always_comb begin
    case (op)
      OP_SLL, OP_SRL, OP_SRA, OP_ROL, OP_ROR: shift_result = shift_out;
      OP_BEXT: shift_result = {{(XLEN-1){1'b0}}, shift_out[0]};
      OP_BSET: shift_result = a | onehot;
      OP_BCLR: shift_result = a & ~onehot;
      OP_BINV: shift_result = a ^ onehot;
      default: shift_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/bmu_bitcount.sv ====
// clz, ctz and cpop over all 32 bits
// clz/ctz of zero give 32; counts are zero-extended to XLEN
`default_nettype none

module bmu_bitcount (
  input  bmu_pkg::bmu_op_e              op,
  input  logic [bmu_pkg::XLEN-1:0]      a,
  output logic [bmu_pkg::XLEN-1:0]      count_result
);
  import bmu_pkg::*;

  logic [XLEN-1:0]    lzd_in;
  logic [COUNT_W-1:0] lz_cnt;
  logic [COUNT_W-1:0] pop_cnt;
  logic               found;

  // ctz reuses the leading-zero loop on bit-reversed a
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      lzd_in[i] = (op == OP_CTZ) ? a[XLEN-1-i] : a[i];
    end
  end

  // count zeros from msb until first one
  always_comb begin
    lz_cnt = '0;
    found  = 1'b0;
    for (int i = XLEN-1; i >= 0; i--) begin
      if (!found && !lzd_in[i]) begin
        lz_cnt = lz_cnt + 1'b1;
      end else begin
        found = 1'b1;
      end
    end
  end

  // population count over the full width
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_cnt = pop_cnt + {{(COUNT_W-1){1'b0}}, a[i]};
    end
  end

  always_comb begin
    case (op)
      OP_CLZ, OP_CTZ: count_result = {{(XLEN-COUNT_W){1'b0}}, lz_cnt};
      OP_CPOP:        count_result = {{(XLEN-COUNT_W){1'b0}}, pop_cnt};
      default:        count_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/bmu_logic.sv ====
// bitwise logic, inverted logic, sign extension, pack and byte ops
// pack places b in the upper half and a in the lower half
// purely combinational; output is zero for other opcodes
`default_nettype none

module bmu_logic (
  input  bmu_pkg::bmu_op_e              op,
  input  logic [bmu_pkg::XLEN-1:0]      a,
  input  logic [bmu_pkg::XLEN-1:0]      b,
  output logic [bmu_pkg::XLEN-1:0]      logic_result
);
  import bmu_pkg::*;

  logic [XLEN-1:0] rev8;
  logic [XLEN-1:0] orc_b;

  // byte swap and per-byte or-combine
  always_comb begin
    for (int i = 0; i < XLEN/8; i++) begin
      rev8[8*i +: 8]  = a[XLEN-8-8*i +: 8];
      // any set bit fills the byte
      orc_b[8*i +: 8] = {8{|a[8*i +: 8]}};
    end
  end

  always_comb begin
    case (op)
      OP_AND:    logic_result = a & b;
      OP_OR:     logic_result = a | b;
      OP_XOR:    logic_result = a ^ b;
      // zbb inverted forms invert b
      OP_ANDN:   logic_result = a & ~b;
      OP_ORN:    logic_result = a | ~b;
      OP_XNOR:   logic_result = ~(a ^ b);
      OP_SEXT_B: logic_result = {{(XLEN-8){a[7]}}, a[7:0]};
      OP_SEXT_H: logic_result = {{(XLEN-16){a[15]}}, a[15:0]};
      // low halves
      OP_PACK:   logic_result = {b[15:0], a[15:0]};
      // high halves
      OP_PACKU:  logic_result = {b[31:16], a[31:16]};
      // zero-extended low bytes
      OP_PACKH:  logic_result = {16'b0, b[7:0], a[7:0]};
      OP_REV8:   logic_result = rev8;
      OP_ORC_B:  logic_result = orc_b;
      default:   logic_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/bmu_top.sv ====
// registered bit-manipulation execute unit, one op per cycle
// result_ff and error load together one clock after valid_in; both hold otherwise
// a csr read must come with OP_NONE; any other op with csr_ren_in is an error
// no back-pressure; the caller may issue every cycle
`default_nettype none

module bmu_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          valid_in,
  input  bmu_pkg::bmu_op_e              op,
  input  logic [bmu_pkg::XLEN-1:0]      a_in,
  input  logic [bmu_pkg::XLEN-1:0]      b_in,
  input  logic                          csr_ren_in,
  input  logic [bmu_pkg::XLEN-1:0]      csr_rddata_in,
  output logic [bmu_pkg::XLEN-1:0]      result_ff,
  output logic                          error
);
  import bmu_pkg::*;

  logic [XLEN-1:0] arith_result;
  logic [XLEN-1:0] shift_result;
  logic [XLEN-1:0] count_result;
  logic [XLEN-1:0] logic_result;
  logic [XLEN-1:0] csr_result;
  logic [XLEN-1:0] merged;
  logic [XLEN-1:0] result_nxt;
  logic            op_illegal;
  logic            csr_conflict;
  logic            error_nxt;

  // adder, compares, min/max
  bmu_arith arith_i (
    .op           (op),
    .a            (a_in),
    .b            (b_in),
    .arith_result (arith_result)
  );

  // shifter, rotates, single-bit ops
  bmu_shift shift_i (
    .op           (op),
    .a            (a_in),
    .b            (b_in),
    .shift_result (shift_result)
  );

  // clz/ctz/cpop use only a
  bmu_bitcount bitcount_i (
    .op           (op),
    .a            (a_in),
    .count_result (count_result)
  );

  // logic, sext, pack, byte ops
  bmu_logic logic_i (
    .op           (op),
    .a            (a_in),
    .b            (b_in),
    .logic_result (logic_result)
  );

  // undefined encodings
  assign op_illegal   = (op > OP_LAST);
  // csr read cannot share the cycle with an op
  assign csr_conflict = csr_ren_in && (op != OP_NONE);
  assign error_nxt    = op_illegal || csr_conflict;

  // csr data only when selected
  assign csr_result = {XLEN{csr_ren_in}} & csr_rddata_in;

  // units are zero when not selected, so an or merges them
  assign merged = arith_result | shift_result | count_result |
                  logic_result | csr_result;

  // errored ops return zero
  assign result_nxt = error_nxt ? '0 : merged;

  // result and error register, loads on valid_in
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_ff <= '0;
      error     <= 1'b0;
    end else if (valid_in) begin
      result_ff <= result_nxt;
      error     <= error_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== verification/bmu_tb.sv ====
// table-driven testbench for bmu_top
// each row is driven on a falling edge and checked on the next falling edge
// rows with valid low expect the previous result and error to hold
`default_nettype none

module bmu_tb;
  import bmu_pkg::*;

  // one stimulus/response row with its name kept in a parallel queue
  typedef struct packed {
    logic [OP_W-1:0] code;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            csr_ren;
    logic [XLEN-1:0] csr;
    logic            valid;
    logic [XLEN-1:0] exp_result;
    logic            exp_error;
  } row_t;

  logic            clk = 1'b0;
  logic            arst_n;
  logic            valid_in;
  bmu_op_e         op;
  logic [XLEN-1:0] a_in;
  logic [XLEN-1:0] b_in;
  logic            csr_ren_in;
  logic [XLEN-1:0] csr_rddata_in;
  logic [XLEN-1:0] result_ff;
  logic            error;

  row_t  rows[$];
  string names[$];
  int    errors = 0;
  int    cycles = 0;
  // replaced once the table length is known
  int    limit  = 1000;

  bmu_top dut_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .valid_in      (valid_in),
    .op            (op),
    .a_in          (a_in),
    .b_in          (b_in),
    .csr_ren_in    (csr_ren_in),
    .csr_rddata_in (csr_rddata_in),
    .result_ff     (result_ff),
    .error         (error)
  );

  always #4 clk = ~clk;

  // abort a run that never reaches the end of the table
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic append_row(input string name, input logic [OP_W-1:0] code,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic csr_ren, input logic [XLEN-1:0] csr,
                            input logic valid, input logic [XLEN-1:0] exp_result,
                            input logic exp_error);
    names.push_back(name);
    rows.push_back('{code, a, b, csr_ren, csr, valid, exp_result, exp_error});
  endtask

  // legal op, no csr read, valid high, no error
  task automatic simple_op(input string name, input bmu_op_e code, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp_result);
    append_row(name, code, a, b, 1'b0, '0, 1'b1, exp_result, 1'b0);
  endtask

  task automatic check_outputs(input string name, input logic [XLEN-1:0] exp_result,
                               input logic exp_error);
    assert (result_ff === exp_result) else begin
      errors++;
      $display("Fail %s: result expected %h actual %h", name, exp_result, result_ff);
    end
    assert (error === exp_error) else begin
      errors++;
      $display("Fail %s: error expected %b actual %b", name, exp_error, error);
    end
  endtask

  task automatic fill_table();
    // adder group, compares, min/max
    simple_op("add", OP_ADD, 32'h12345678, 32'h11111111, 32'h23456789);
    simple_op("sub_wrap", OP_SUB, 32'h00000001, 32'h00000002, 32'hffffffff);
    simple_op("sh1add", OP_SH1ADD, 32'h00000003, 32'h00000005, 32'h0000000b);
    simple_op("sh2add", OP_SH2ADD, 32'h40000001, 32'h00000010, 32'h00000014);
    simple_op("sh3add", OP_SH3ADD, 32'h00000003, 32'hffffffff, 32'h00000017);
    simple_op("slt", OP_SLT, 32'hffffffff, 32'h00000001, 32'h00000001);
    simple_op("sltu", OP_SLTU, 32'hffffffff, 32'h00000001, 32'h00000000);
    // signed overflow in the compare
    simple_op("slt_ovf", OP_SLT, 32'h80000000, 32'h7fffffff, 32'h00000001);
    simple_op("min", OP_MIN, 32'hffffffff, 32'h00000001, 32'hffffffff);
    simple_op("max", OP_MAX, 32'hffffffff, 32'h00000001, 32'h00000001);
    simple_op("minu", OP_MINU, 32'hffffffff, 32'h00000001, 32'h00000001);
    simple_op("maxu", OP_MAXU, 32'hffffffff, 32'h00000001, 32'hffffffff);
    // logic, sign extension, packing, byte ops
    simple_op("and", OP_AND, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
    simple_op("or", OP_OR, 32'hf0f0f0f0, 32'hff00ff00, 32'hfff0fff0);
    simple_op("xor", OP_XOR, 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0);
    simple_op("andn", OP_ANDN, 32'hf0f0f0f0, 32'hff00ff00, 32'h00f000f0);
    simple_op("orn", OP_ORN, 32'hf0f0f0f0, 32'hff00ff00, 32'hf0fff0ff);
    simple_op("xnor", OP_XNOR, 32'hf0f0f0f0, 32'hff00ff00, 32'hf00ff00f);
    simple_op("sext_b", OP_SEXT_B, 32'h12345680, 32'h0, 32'hffffff80);
    simple_op("sext_h", OP_SEXT_H, 32'h00018000, 32'h0, 32'hffff8000);
    simple_op("pack", OP_PACK, 32'h11223344, 32'h55667788, 32'h77883344);
    simple_op("packu", OP_PACKU, 32'h11223344, 32'h55667788, 32'h55661122);
    simple_op("packh", OP_PACKH, 32'h11223344, 32'h55667788, 32'h00008844);
    simple_op("rev8", OP_REV8, 32'h11223344, 32'h0, 32'h44332211);
    simple_op("orc_b", OP_ORC_B, 32'h00100300, 32'h0, 32'h00ffff00);
    // shifts, rotates, single bits
    simple_op("sll_0", OP_SLL, 32'h80000001, 32'd0, 32'h80000001);
    simple_op("sll_1", OP_SLL, 32'h80000001, 32'd1, 32'h00000002);
    simple_op("sll_31", OP_SLL, 32'h80000001, 32'd31, 32'h80000000);
    simple_op("srl_0", OP_SRL, 32'h80000001, 32'd0, 32'h80000001);
    simple_op("srl_1", OP_SRL, 32'h80000001, 32'd1, 32'h40000000);
    simple_op("srl_31", OP_SRL, 32'h80000001, 32'd31, 32'h00000001);
    simple_op("sra_0", OP_SRA, 32'h80000001, 32'd0, 32'h80000001);
    simple_op("sra_1", OP_SRA, 32'h80000001, 32'd1, 32'hc0000000);
    simple_op("sra_31", OP_SRA, 32'h80000001, 32'd31, 32'hffffffff);
    // 33 acts as 1
    simple_op("sra_b33", OP_SRA, 32'h80000001, 32'd33, 32'hc0000000);
    simple_op("rol", OP_ROL, 32'h80000001, 32'd4, 32'h00000018);
    simple_op("ror", OP_ROR, 32'h80000001, 32'd4, 32'h18000000);
    simple_op("bext_1", OP_BEXT, 32'h00000400, 32'd10, 32'h00000001);
    simple_op("bext_0", OP_BEXT, 32'h00000400, 32'd11, 32'h00000000);
    simple_op("bset", OP_BSET, 32'h00000000, 32'd31, 32'h80000000);
    simple_op("bclr", OP_BCLR, 32'hffffffff, 32'd4, 32'hffffffef);
    simple_op("binv", OP_BINV, 32'h0000000f, 32'h00000023, 32'h00000007);
    // counts
    simple_op("clz_0", OP_CLZ, 32'h00000000, 32'h0, 32'h00000020);
    simple_op("ctz_0", OP_CTZ, 32'h00000000, 32'h0, 32'h00000020);
    simple_op("cpop_0", OP_CPOP, 32'h00000000, 32'h0, 32'h00000000);
    simple_op("clz_ones", OP_CLZ, 32'hffffffff, 32'h0, 32'h00000000);
    simple_op("ctz_ones", OP_CTZ, 32'hffffffff, 32'h0, 32'h00000000);
    simple_op("cpop_ones", OP_CPOP, 32'hffffffff, 32'h0, 32'h00000020);
    simple_op("clz_bit", OP_CLZ, 32'h00010000, 32'h0, 32'h0000000f);
    simple_op("ctz_bit", OP_CTZ, 32'h00010000, 32'h0, 32'h00000010);
    simple_op("cpop_high", OP_CPOP, 32'h80010000, 32'h0, 32'h00000002);
    // csr path, errors, hold
    append_row("csr_read", OP_NONE, '0, '0, 1'b1, 32'ha5a51234, 1'b1, 32'ha5a51234, 1'b0);
    append_row("csr_conflict", OP_ADD, 32'h1, 32'h2, 1'b1, 32'ha5a51234, 1'b1, '0, 1'b1);
    simple_op("add_after", OP_ADD, 32'h1, 32'h2, 32'h3);
    append_row("hold", OP_SUB, 32'h9, 32'h1, 1'b0, '0, 1'b0, 32'h3, 1'b0);
    append_row("illegal_op", OP_LAST + 6'd1, 32'h1, 32'h1, 1'b0, '0, 1'b1, '0, 1'b1);
    append_row("hold_err", OP_ADD, 32'h5, 32'h5, 1'b0, '0, 1'b0, '0, 1'b1);
  endtask

  initial begin
    arst_n        = 1'b0;
    valid_in      = 1'b0;
    op            = OP_NONE;
    a_in          = '0;
    b_in          = '0;
    csr_ren_in    = 1'b0;
    csr_rddata_in = '0;
    fill_table();
    limit = 2 * rows.size() + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_outputs("after_reset", '0, 1'b0);
    foreach (rows[i]) begin
      op            = bmu_op_e'(rows[i].code);
      a_in          = rows[i].a;
      b_in          = rows[i].b;
      csr_ren_in    = rows[i].csr_ren;
      csr_rddata_in = rows[i].csr;
      valid_in      = rows[i].valid;
      // register loads on the rising edge in between
      @(negedge clk);
      check_outputs(names[i], rows[i].exp_result, rows[i].exp_error);
    end
    $display("errors: %0d over %0d rows", errors, rows.size());
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bmu.f ====
design/bmu_pkg.sv
design/bmu_arith.sv
design/bmu_shift.sv
design/bmu_bitcount.sv
design/bmu_logic.sv
design/bmu_top.sv
verification/bmu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := bmu_tb
FILELIST   := bmu.f
FLAGS      := --binary --timing -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
